//--- verilog/icache_geom_pkg.sv
// Instruction cache geometry
package icache_geom_pkg;

	// 4 ways x 16 sets x 64 byte lines
	parameter int WAYS       = 4;
	parameter int SETS       = 16;
	parameter int TAG_W      = 22;
	parameter int INDEX_W    = 4;
	parameter int WORD_SEL_W = 3;  // 8 words per line
	parameter int BYTE_W     = 3;  // Byte within a 64-bit word
	parameter int WORD_W     = 64;
	parameter int LINE_W     = 512;
	parameter int STATUS_W   = 2;

	typedef logic [1:0] way_t;
	typedef logic [STATUS_W-1:0] status_t;  // 0 invalid, 1 oldest, 3 newest

	parameter status_t ST_INVALID = 2'd0;
	parameter status_t ST_NEWEST  = 2'd3;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [LINE_W-1:0] line_t;

	// Names one cache line
	typedef struct packed {
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] index;
	} line_addr_t;

	typedef struct packed {
		line_addr_t            line;
		logic [WORD_SEL_W-1:0] word_sel;
		logic [BYTE_W-1:0]     byte_off;  // Ignored by the cache
	} cache_addr_t;

	typedef struct packed {
		status_t          status;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

endpackage

//--- verilog/icache_port_pkg.sv
// Instruction cache port types
package icache_port_pkg;

	// Read request, full byte address
	typedef struct packed {
		icache_geom_pkg::cache_addr_t addr;
	} rd_req_t;

	// Read response, data zero on a miss
	typedef struct packed {
		logic                   hit;
		icache_geom_pkg::word_t data;
	} rd_rsp_t;

	// Whole line fill
	typedef struct packed {
		icache_geom_pkg::line_addr_t addr;
		icache_geom_pkg::line_t      line;
	} fill_t;

	// Directory result handed to the word select stage
	typedef struct packed {
		logic                                    hit;
		icache_geom_pkg::way_t                   way;
		logic [icache_geom_pkg::WORD_SEL_W-1:0]  word_sel;
	} lookup_t;

endpackage

//--- verilog/icache_tag_directory.sv
// Instruction cache tag directory
`timescale 1ns/1ps

module icache_tag_directory #(
	parameter int AGE_PERIOD = 65536
) (
	input  logic                          iCLOCK,
	input  logic                          inRESET,
	input  logic                          rd_en,
	input  icache_geom_pkg::cache_addr_t  rd_addr,
	input  logic                          stall,
	input  logic                          fill_valid,
	input  icache_geom_pkg::line_addr_t   fill_addr,
	output icache_port_pkg::lookup_t      lookup,
	output icache_geom_pkg::way_t         fill_way
);

	localparam int TIMER_W = (AGE_PERIOD > 1) ? $clog2(AGE_PERIOD) : 1;

	// Status and tag per way and set
	icache_geom_pkg::tag_entry_t tags [icache_geom_pkg::WAYS][icache_geom_pkg::SETS];

	logic [TIMER_W-1:0] age_timer;
	logic               age_tick;

	// Lookup of the read set
	always_comb begin
		lookup.hit      = 1'b0;
		lookup.way      = '0;
		lookup.word_sel = rd_addr.word_sel;
		// Walk down so the lowest matching way wins
		for (int w = icache_geom_pkg::WAYS - 1; w >= 0; w--) begin
			if (tags[w][rd_addr.line.index].tag == rd_addr.line.tag &&
					tags[w][rd_addr.line.index].status != icache_geom_pkg::ST_INVALID) begin
				lookup.hit = 1'b1;
				lookup.way = icache_geom_pkg::way_t'(w);
			end
		end
	end

	// Victim choice, passes run from lowest to highest priority
	always_comb begin
		fill_way = icache_geom_pkg::way_t'(icache_geom_pkg::WAYS - 1);  // All ways newest
		for (int s = 2; s >= 0; s--) begin
			for (int w = icache_geom_pkg::WAYS - 1; w >= 0; w--) begin
				if (int'(tags[w][fill_addr.index].status) == s) begin
					fill_way = icache_geom_pkg::way_t'(w);
				end
			end
		end
		// Resident line is refilled in place, status ignored
		for (int w = icache_geom_pkg::WAYS - 1; w >= 0; w--) begin
			if (tags[w][fill_addr.index].tag == fill_addr.tag) begin
				fill_way = icache_geom_pkg::way_t'(w);
			end
		end
	end

	// Age timer, paused while the response side stalls
	assign age_tick = !stall && (int'(age_timer) == AGE_PERIOD - 1);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			age_timer <= '0;
		end else if (age_tick) begin
			age_timer <= '0;  // Wrap
		end else if (!stall) begin
			age_timer <= age_timer + 1'b1;
		end
	end

	// Status and tag update
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int w = 0; w < icache_geom_pkg::WAYS; w++) begin
				for (int s = 0; s < icache_geom_pkg::SETS; s++) begin
					tags[w][s] <= '0;  // Everything invalid
				end
			end
		end else if (fill_valid) begin
			// Fill owns the cycle, a coinciding tick is dropped
			tags[fill_way][fill_addr.index].status <= icache_geom_pkg::ST_NEWEST;
			tags[fill_way][fill_addr.index].tag    <= fill_addr.tag;
		end else begin
			for (int w = 0; w < icache_geom_pkg::WAYS; w++) begin
				for (int s = 0; s < icache_geom_pkg::SETS; s++) begin
					if (rd_en && lookup.hit && int'(lookup.way) == w &&
							int'(rd_addr.line.index) == s) begin
						tags[w][s].status <= icache_geom_pkg::ST_NEWEST;  // Refresh on hit
					end else if (age_tick && tags[w][s].status[1]) begin
						// Decay 3 to 2 and 2 to 1, oldest stays
						tags[w][s].status <= tags[w][s].status - 1'b1;
					end
				end
			end
		end
	end

endmodule

//--- verilog/icache_line_store.sv
// Instruction cache line data store
`timescale 1ns/1ps

module icache_line_store (
	input  logic                                iCLOCK,
	input  logic                                rd_en,
	input  logic [icache_geom_pkg::INDEX_W-1:0] rd_index,
	input  logic                                wr_en,
	input  icache_geom_pkg::way_t               wr_way,
	input  logic [icache_geom_pkg::INDEX_W-1:0] wr_index,
	input  icache_geom_pkg::line_t              wr_line,
	output icache_geom_pkg::line_t              way_lines [icache_geom_pkg::WAYS]
);

	// One 16 entry memory per way
	icache_geom_pkg::line_t mem [icache_geom_pkg::WAYS][icache_geom_pkg::SETS];

	// Whole line write into the victim way
	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			mem[wr_way][wr_index] <= wr_line;
		end
	end

	// All ways read together, tag check picks one later
	// Same edge write lands after the read, old line comes out
	always_ff @(posedge iCLOCK) begin
		if (rd_en) begin
			for (int w = 0; w < icache_geom_pkg::WAYS; w++) begin
				way_lines[w] <= mem[w][rd_index];
			end
		end
		// Held otherwise, response may be stalled
	end

endmodule

//--- verilog/icache_word_select.sv
// Instruction cache response stage
`timescale 1ns/1ps

module icache_word_select (
	input  logic                      iCLOCK,
	input  logic                      inRESET,
	input  logic                      rd_en,
	input  logic                      stall,
	input  icache_port_pkg::lookup_t  lookup,
	input  icache_geom_pkg::line_t    way_lines [icache_geom_pkg::WAYS],
	output logic                      rsp_valid,
	output icache_port_pkg::rd_rsp_t  rsp
);

	logic                     rsp_pending;  // Accepted request in this stage
	icache_port_pkg::lookup_t lookup_q;
	icache_geom_pkg::line_t   hit_line;
	icache_geom_pkg::word_t   hit_word;

	// Register stage, frozen while the consumer is busy
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			rsp_pending <= 1'b0;
			lookup_q    <= '0;
		end else if (!stall) begin
			rsp_pending <= rd_en;
			lookup_q    <= lookup;
		end
	end

	// Held response shows up again once the stall drops
	assign rsp_valid = rsp_pending && !stall;

	// Way mux then word slice
	assign hit_line = way_lines[lookup_q.way];
	assign hit_word = hit_line[lookup_q.word_sel * icache_geom_pkg::WORD_W +:
			icache_geom_pkg::WORD_W];

	always_comb begin
		rsp.hit  = lookup_q.hit;
		rsp.data = lookup_q.hit ? hit_word : '0;  // Zero on miss
	end

endmodule

//--- verilog/l1_icache.sv
// L1 instruction cache top
`timescale 1ns/1ps

module l1_icache #(
	parameter int AGE_PERIOD = 65536
) (
	input  logic                      iCLOCK,
	input  logic                      inRESET,
	input  logic                      rd_req_valid,
	input  icache_port_pkg::rd_req_t  rd_req,
	output logic                      rd_busy,
	output logic                      rsp_valid,
	output icache_port_pkg::rd_rsp_t  rsp,
	input  logic                      rsp_busy,
	input  logic                      fill_valid,
	input  icache_port_pkg::fill_t    fill
);

	logic                     rd_en;
	icache_port_pkg::lookup_t lookup;
	icache_geom_pkg::way_t    fill_way;
	icache_geom_pkg::line_t   way_lines [icache_geom_pkg::WAYS];

	// Stall, or a fill to the very line being read
	assign rd_busy = rsp_busy ||
			(rd_req_valid && fill_valid && rd_req.addr.line == fill.addr);
	assign rd_en   = rd_req_valid && !rd_busy;  // Request accepted

	icache_tag_directory #(
		.AGE_PERIOD (AGE_PERIOD)
	) i_tag_directory (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.rd_en      (rd_en),
		.rd_addr    (rd_req.addr),
		.stall      (rsp_busy),
		.fill_valid (fill_valid),
		.fill_addr  (fill.addr),
		.lookup     (lookup),
		.fill_way   (fill_way)
	);

	icache_line_store i_line_store (
		.iCLOCK    (iCLOCK),
		.rd_en     (rd_en),
		.rd_index  (rd_req.addr.line.index),
		.wr_en     (fill_valid),
		.wr_way    (fill_way),  // Victim from the directory
		.wr_index  (fill.addr.index),
		.wr_line   (fill.line),
		.way_lines (way_lines)
	);

	icache_word_select i_word_select (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.rd_en     (rd_en),
		.stall     (rsp_busy),
		.lookup    (lookup),
		.way_lines (way_lines),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

endmodule

//--- dv/l1_icache_assertions.sv
// Cache handshake assertions
`timescale 1ns/1ps

module l1_icache_assertions (
	input logic                     iCLOCK,
	input logic                     inRESET,
	input logic                     rsp_busy,
	input logic                     rsp_valid,
	input icache_port_pkg::rd_rsp_t rsp
);

	int fail_count = 0;  // Tally of failed assertions

	// Nothing delivered while the consumer is busy
	no_valid_when_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET)
			rsp_busy |-> !rsp_valid)
		else begin
			$error("rsp_valid high while rsp_busy is high");
			fail_count++;
		end

	no_valid_in_reset: assert property (@(posedge iCLOCK) !inRESET |-> !rsp_valid)
		else begin
			$error("rsp_valid high during reset");
			fail_count++;
		end

	// Stage frozen by a stall at the previous edge
	rsp_held_in_stall: assert property (@(posedge iCLOCK) disable iff (!inRESET)
			$past(rsp_busy) |-> $stable(rsp))
		else begin
			$error("rsp changed while stalled");
			fail_count++;
		end

endmodule

//--- dv/l1_icache_tb.sv
// L1 instruction cache testbench
`timescale 1ns/1ps

module l1_icache_tb;

	localparam int AGE_PERIOD     = 16;  // Short period for frequent ticks
	localparam int N_COLD         = 24;
	localparam int N_DIRECTED     = 35;  // Three fills and four line reads
	localparam int N_RAND         = 2000;
	localparam int TOTAL_CYCLES   = 10 + N_COLD + N_DIRECTED + N_RAND + 4;
	localparam int TIMEOUT_CYCLES = 3 * TOTAL_CYCLES;

	logic                     iCLOCK;
	logic                     inRESET;
	logic                     rd_req_valid;
	icache_port_pkg::rd_req_t rd_req;
	logic                     rd_busy;
	logic                     rsp_valid;
	icache_port_pkg::rd_rsp_t rsp;
	logic                     rsp_busy;
	logic                     fill_valid;
	icache_port_pkg::fill_t   fill;

	// Reference model state
	icache_geom_pkg::tag_entry_t m_tags [icache_geom_pkg::WAYS][icache_geom_pkg::SETS];
	icache_geom_pkg::line_t      m_data [icache_geom_pkg::WAYS][icache_geom_pkg::SETS];
	int                          m_timer = 0;
	icache_port_pkg::rd_rsp_t    exp_q [$];  // Accepted but not yet delivered

	integer                      seed = 32'h77c9;
	int                          cycles = 0;
	icache_geom_pkg::line_addr_t la;
	icache_geom_pkg::line_addr_t lb;
	icache_port_pkg::rd_req_t    rq_r;
	icache_port_pkg::fill_t      fl_r;

	l1_icache #(
		.AGE_PERIOD (AGE_PERIOD)
	) i_dut (
		.iCLOCK       (iCLOCK),
		.inRESET      (inRESET),
		.rd_req_valid (rd_req_valid),
		.rd_req       (rd_req),
		.rd_busy      (rd_busy),
		.rsp_valid    (rsp_valid),
		.rsp          (rsp),
		.rsp_busy     (rsp_busy),
		.fill_valid   (fill_valid),
		.fill         (fill)
	);

	bind l1_icache l1_icache_assertions i_assertions (
		.iCLOCK    (iCLOCK),
		.inRESET   (inRESET),
		.rsp_busy  (rsp_busy),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	always #2 iCLOCK = ~iCLOCK;  // 4 ns period

	always @(posedge iCLOCK) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			abort_run($sformatf("Run timed out after %0d cycles", cycles));
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("tests failed");
		$fatal(1, "Run stopped");
	endtask

	task automatic report_mismatch(input string what);
		abort_run($sformatf("Error at time %0t: %s", $time, what));
	endtask

	task automatic check_rsp(input icache_port_pkg::rd_rsp_t exp);
		if (rsp !== exp) begin
			report_mismatch($sformatf("rsp hit %0b data %h, expected hit %0b data %h",
					rsp.hit, rsp.data, exp.hit, exp.data));
		end
	endtask

	task automatic check_busy(input logic exp);
		if (rd_busy !== exp) begin
			report_mismatch($sformatf("rd_busy %b, expected %b", rd_busy, exp));
		end
	endtask

	task automatic check_valid(input logic exp);
		if (rsp_valid !== exp) begin
			report_mismatch($sformatf("rsp_valid %b, expected %b", rsp_valid, exp));
		end
	endtask

	// Matching tag first then lowest status then way 3
	function automatic icache_geom_pkg::way_t pick_victim(input icache_geom_pkg::line_addr_t a);
		for (int w = 0; w < icache_geom_pkg::WAYS; w++) begin
			if (m_tags[w][a.index].tag == a.tag) return icache_geom_pkg::way_t'(w);
		end
		for (int st = 0; st < 3; st++) begin
			for (int w = 0; w < icache_geom_pkg::WAYS; w++) begin
				if (int'(m_tags[w][a.index].status) == st) return icache_geom_pkg::way_t'(w);
			end
		end
		return icache_geom_pkg::way_t'(3);
	endfunction

	function automatic icache_geom_pkg::line_t rand_line();
		icache_geom_pkg::line_t l;
		for (int i = 0; i < 16; i++) begin
			l[i * 32 +: 32] = $random(seed);
		end
		return l;
	endfunction

	// Eight tags over two sets for frequent conflicts
	function automatic icache_geom_pkg::line_addr_t rand_line_addr();
		icache_geom_pkg::line_addr_t a;
		a.tag   = {19'h54, 3'($random(seed))};
		a.index = (($random(seed) & 1) != 0) ? 4'd9 : 4'd3;
		return a;
	endfunction

	// One cycle driven on the falling edge and checked before the rise
	task automatic step(input logic rv, input icache_port_pkg::rd_req_t rq, input logic fv,
			input icache_port_pkg::fill_t fl, input logic busy);
		logic                         exp_busy;
		logic                         accept;
		logic                         hit;
		logic                         tick;
		icache_geom_pkg::way_t        hway;
		icache_geom_pkg::way_t        vway;
		icache_geom_pkg::cache_addr_t ra;
		icache_port_pkg::rd_rsp_t     exp;
		rd_req_valid = rv;
		rd_req       = rq;
		fill_valid   = fv;
		fill         = fl;
		rsp_busy     = busy;
		#1;
		if (i_dut.i_assertions.fail_count != 0) begin
			abort_run("Bound assertions reported failures");
		end
		ra       = rq.addr;
		exp_busy = busy || (rv && fv && ra.line == fl.addr);  // Stall or same line fill
		check_busy(exp_busy);
		if (exp_q.size() > 0 && !busy) begin
			check_valid(1'b1);
			check_rsp(exp_q.pop_front());
		end else begin
			check_valid(1'b0);
		end
		hit  = 1'b0;
		hway = '0;
		for (int w = 0; w < icache_geom_pkg::WAYS; w++) begin
			if (!hit && m_tags[w][ra.line.index].status != 2'd0 &&
					m_tags[w][ra.line.index].tag == ra.line.tag) begin
				hit  = 1'b1;
				hway = icache_geom_pkg::way_t'(w);
			end
		end
		accept = rv && !exp_busy;
		if (accept) begin
			exp.hit  = hit;
			exp.data = hit ? m_data[hway][ra.line.index][ra.word_sel * 64 +: 64] : '0;
			exp_q.push_back(exp);  // Old tags and data even beside a fill
		end
		tick = !busy && m_timer == AGE_PERIOD - 1;
		if (!busy) m_timer = tick ? 0 : m_timer + 1;
		if (fv) begin
			vway = pick_victim(fl.addr);
			m_tags[vway][fl.addr.index].status = 2'd3;
			m_tags[vway][fl.addr.index].tag    = fl.addr.tag;
			m_data[vway][fl.addr.index]        = fl.line;
		end else begin
			for (int w = 0; w < icache_geom_pkg::WAYS; w++) begin
				for (int s = 0; s < icache_geom_pkg::SETS; s++) begin
					if (accept && hit && int'(hway) == w && int'(ra.line.index) == s) begin
						m_tags[w][s].status = 2'd3;  // Refresh
					end else if (tick && m_tags[w][s].status >= 2'd2) begin
						m_tags[w][s].status = m_tags[w][s].status - 2'd1;
					end
				end
			end
		end
		@(negedge iCLOCK);
	endtask

	task automatic fill_line(input icache_geom_pkg::line_addr_t a,
			input icache_geom_pkg::line_t l);
		icache_port_pkg::fill_t fl;
		fl.addr = a;
		fl.line = l;
		step(1'b0, '0, 1'b1, fl, 1'b0);
	endtask

	// All eight words of one line
	task automatic read_line(input icache_geom_pkg::line_addr_t a);
		icache_port_pkg::rd_req_t rq;
		for (int w = 0; w < 8; w++) begin
			rq.addr.line     = a;
			rq.addr.word_sel = 3'(w);
			rq.addr.byte_off = '0;
			step(1'b1, rq, 1'b0, '0, 1'b0);
		end
	endtask

	initial begin
		iCLOCK       = 1'b0;
		inRESET      = 1'b1;
		rd_req_valid = 1'b0;
		rd_req       = '0;
		rsp_busy     = 1'b0;
		fill_valid   = 1'b0;
		fill         = '0;
		for (int w = 0; w < icache_geom_pkg::WAYS; w++) begin
			for (int s = 0; s < icache_geom_pkg::SETS; s++) begin
				m_tags[w][s] = '0;
				m_data[w][s] = '0;
			end
		end
		#1;
		inRESET = 1'b0;  // Falling edge starts the asynchronous reset
		repeat (10) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		// Cold cache where any address misses
		repeat (N_COLD) step(($random(seed) & 3) != 0, icache_port_pkg::rd_req_t'($random(seed)),
				1'b0, '0, 1'b0);
		// Two lines in one set and the first one refilled in place
		la = '{tag: 22'h1234, index: 4'd5};
		lb = '{tag: 22'h0777, index: 4'd5};
		fill_line(la, rand_line());
		fill_line(lb, rand_line());
		read_line(la);
		read_line(lb);
		fill_line(la, rand_line());
		read_line(la);
		read_line(lb);
		// Mixed reads, fills and stalls
		repeat (N_RAND) begin
			rq_r.addr.line     = rand_line_addr();
			rq_r.addr.word_sel = 3'($random(seed));
			rq_r.addr.byte_off = 3'($random(seed));
			fl_r.addr          = rand_line_addr();
			fl_r.line          = rand_line();
			if (($random(seed) & 7) == 0) fl_r.addr = rq_r.addr.line;  // Force a collision
			step(($random(seed) & 3) != 0, rq_r, ($random(seed) & 3) == 0, fl_r,
					($random(seed) & 3) == 0);
		end
		repeat (4) step(1'b0, '0, 1'b0, '0, 1'b0);  // Drain
		if (exp_q.size() != 0) begin
			abort_run($sformatf("%0d responses were never delivered", exp_q.size()));
		end
		if (i_dut.i_assertions.fail_count == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			abort_run("Bound assertions reported failures");
		end
	end

endmodule

//--- l1_icache.f
verilog/icache_geom_pkg.sv
verilog/icache_port_pkg.sv
verilog/icache_tag_directory.sv
verilog/icache_line_store.sv
verilog/icache_word_select.sv
verilog/l1_icache.sv
dv/l1_icache_assertions.sv
dv/l1_icache_tb.sv

//--- Bender.yml
package:
  name: l1_icache

sources:
  - files:
      - verilog/icache_geom_pkg.sv
      - verilog/icache_port_pkg.sv
      - verilog/icache_tag_directory.sv
      - verilog/icache_line_store.sv
      - verilog/icache_word_select.sv
      - verilog/l1_icache.sv
  - target: test
    files:
      - dv/l1_icache_assertions.sv
      - dv/l1_icache_tb.sv
